// ==== logic/aether_pkg.sv ====
package aether_pkg;

  // ------------------------------
  // Widths with a meaning
  // ------------------------------
  typedef logic [15:0] word_t;      // Host and memory data word
  typedef logic [15:0] mem_addr_t;  // Memory word address
  typedef logic [3:0]  reg_idx_t;   // Register index on param_1

  // Host instruction codes, anything else is a NOP
  typedef enum logic [3:0] {
    INSTR_NOP      = 4'h0,
    INSTR_RST      = 4'h1,  // Full reset, memory survives
    INSTR_WREG     = 4'h2,  // param_2 into register param_1
    INSTR_RREG     = 4'h3,  // Register param_1 to data_o
    INSTR_LDW_STRT = 4'h4,  // Restart buffer fill
    INSTR_LDW_CONT = 4'h5,  // Append param_2 to buffer
    INSTR_LDW_MOVE = 4'h6,  // Buffer into memory
    INSTR_MEM_READ = 4'h7   // Memory at param_2 to data_o
  } instr_e;

  // ------------------------------
  // Register map
  // ------------------------------
  localparam reg_idx_t REG_VERSN  = 4'd0;  // Read only
  localparam reg_idx_t REG_MSTRT  = 4'd1;  // First memory address
  localparam reg_idx_t REG_MENDD  = 4'd2;  // Last memory address
  localparam reg_idx_t REG_STATS  = 4'd3;  // Read only, bit 0 done, bit 1 running
  localparam reg_idx_t REG_BUFCNT = 4'd4;  // Read only, buffer fill level

  localparam word_t AETHER_VERSION = 16'h0A31;

  // Decoder to input buffer
  typedef struct packed {
    logic  clear;  // Restart write counter
    logic  write;  // Append data
    word_t data;
  } buf_wr_t;

  // Decoder to mover, addresses inclusive
  typedef struct packed {
    logic      start;
    mem_addr_t first;
    mem_addr_t last;   // first - 1 means nothing to move
  } move_cmd_t;

  // Mover to word memory
  typedef struct packed {
    logic      write;
    mem_addr_t addr;
    word_t     data;
  } mem_wr_t;

  typedef enum logic [1:0] {MOVE_IDLE, MOVE_RUN, MOVE_DRAIN} mover_state_e;

endpackage

// ==== logic/aether_word_mem.sv ====
`timescale 1ns/1ps

module aether_word_mem #(
  parameter int unsigned MemDepth = 256,
  localparam int unsigned IdxW = (MemDepth > 1) ? $clog2(MemDepth) : 1
) (
  input  logic                  clk_i,
  input  aether_pkg::mem_wr_t   mem_wr_i,
  input  aether_pkg::mem_addr_t rd_addr_i,
  output aether_pkg::word_t     rd_data_o
);

  // System memory, contents kept across RST
  aether_pkg::word_t mem [MemDepth];

  logic [IdxW-1:0] wr_idx;
  logic [IdxW-1:0] rd_idx;

  // ------------------------------
  // Address wrap
  // ------------------------------
  assign wr_idx = IdxW'(mem_wr_i.addr % MemDepth);
  assign rd_idx = IdxW'(rd_addr_i % MemDepth);

  // Single write port from the mover
  always_ff @(posedge clk_i) begin
    if (mem_wr_i.write) begin
      mem[wr_idx] <= mem_wr_i.data;
    end
  end

  // Registered read, one cycle
  always_ff @(posedge clk_i) begin
    rd_data_o <= mem[rd_idx];
  end

endmodule

// ==== logic/aether_input_buffer.sv ====
`timescale 1ns/1ps

module aether_input_buffer #(
  parameter int unsigned BufferDepth = 64,
  localparam int unsigned AddrW = $clog2(BufferDepth),
  localparam int unsigned CntW = $clog2(BufferDepth + 1)
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  aether_pkg::buf_wr_t buf_wr_i,
  input  logic [AddrW-1:0]    rd_addr_i,
  output aether_pkg::word_t   rd_data_o,
  output logic [CntW-1:0]     count_o
);

  aether_pkg::word_t buf_mem [BufferDepth];

  logic [CntW-1:0] count_q;  // Next write index, also fill level
  logic            full;
  logic            wr_en;    // Accepted word

  assign full    = (count_q == CntW'(BufferDepth));
  assign wr_en   = buf_wr_i.write && !full && !buf_wr_i.clear;
  assign count_o = count_q;

  // ------------------------------
  // Write counter
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else if (buf_wr_i.clear) begin
      count_q <= '0;                // Restart fill
    end else if (wr_en) begin
      count_q <= count_q + 1'b1;    // Stops at BufferDepth
    end
  end

  // Storage, no reset on contents
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      buf_mem[count_q[AddrW-1:0]] <= buf_wr_i.data;
    end
  end

  // Registered read for the mover
  always_ff @(posedge clk_i) begin
    rd_data_o <= buf_mem[rd_addr_i];
  end

endmodule

// ==== logic/aether_buffer_mover.sv ====
`timescale 1ns/1ps

module aether_buffer_mover #(
  parameter int unsigned BufferDepth = 64,
  localparam int unsigned AddrW = $clog2(BufferDepth)
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  aether_pkg::move_cmd_t move_cmd_i,
  output logic [AddrW-1:0]      buf_rd_addr_o,
  input  aether_pkg::word_t     buf_rd_data_i,
  output aether_pkg::mem_wr_t   mem_wr_o,
  output logic                  busy_o,
  output logic                  done_o
);

  aether_pkg::mover_state_e state_q;

  logic [AddrW-1:0]      rd_idx_q;    // Buffer read index
  aether_pkg::mem_addr_t run_addr_q;  // Target of the word being read
  aether_pkg::mem_addr_t last_q;
  aether_pkg::mem_addr_t wr_addr_q;   // Target of the word arriving now
  logic                  wr_vld_q;    // Read data lands this cycle
  logic                  done_q;
  logic                  empty;       // Zero-length move

  assign empty         = (aether_pkg::mem_addr_t'(move_cmd_i.last + 1'b1) == move_cmd_i.first);
  assign buf_rd_addr_o = rd_idx_q;
  assign busy_o        = move_cmd_i.start || (state_q != aether_pkg::MOVE_IDLE);
  assign done_o        = done_q;

  // Write one cycle behind its read
  assign mem_wr_o.write = wr_vld_q;
  assign mem_wr_o.addr  = wr_addr_q;
  assign mem_wr_o.data  = buf_rd_data_i;

  // ------------------------------
  // Move FSM
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= aether_pkg::MOVE_IDLE;
      rd_idx_q <= '0;
      wr_vld_q <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      wr_vld_q <= (state_q == aether_pkg::MOVE_RUN);
      done_q   <= 1'b0;
      case (state_q)
        aether_pkg::MOVE_IDLE: begin
          rd_idx_q <= '0;
          if (move_cmd_i.start && empty) done_q <= 1'b1;  // Nothing to copy
          else if (move_cmd_i.start) state_q <= aether_pkg::MOVE_RUN;
        end
        aether_pkg::MOVE_RUN: begin
          rd_idx_q <= rd_idx_q + 1'b1;
          if (run_addr_q == last_q) state_q <= aether_pkg::MOVE_DRAIN;  // Last read issued
        end
        aether_pkg::MOVE_DRAIN: begin
          state_q <= aether_pkg::MOVE_IDLE;  // Final write goes out here
          done_q  <= 1'b1;
        end
        default: state_q <= aether_pkg::MOVE_IDLE;
      endcase
    end
  end

  // Address tracking
  always_ff @(posedge clk_i) begin
    wr_addr_q <= run_addr_q;
    if (state_q == aether_pkg::MOVE_IDLE) begin
      run_addr_q <= move_cmd_i.first;
      last_q     <= move_cmd_i.last;
    end else begin
      run_addr_q <= run_addr_q + 1'b1;   // Steps with rd_idx_q
    end
  end

endmodule

// ==== logic/aether_instruct_decoder.sv ====
`timescale 1ns/1ps

module aether_instruct_decoder #(
  parameter int unsigned BufferDepth = 64,
  localparam int unsigned CntW = $clog2(BufferDepth + 1)
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  aether_pkg::instr_e    instruction_i,
  input  aether_pkg::reg_idx_t  param_1_i,
  input  aether_pkg::word_t     param_2_i,
  output aether_pkg::word_t     data_o,
  input  logic [CntW-1:0]       buf_count_i,
  input  logic                  mover_busy_i,
  input  logic                  mover_done_i,
  input  aether_pkg::word_t     mem_rd_data_i,
  output aether_pkg::buf_wr_t   buf_wr_o,
  output aether_pkg::move_cmd_t move_cmd_o,
  output aether_pkg::mem_addr_t mem_rd_addr_o,
  output logic                  interrupt_o
);

  // Decoded strobes, busy gate applied
  logic do_rst, do_wreg, do_rreg, do_strt, do_cont, do_move, do_mread;
  logic range_reg;  // param_1 names MSTRT or MENDD

  aether_pkg::mem_addr_t mstrt_q, mendd_q;
  logic                  done_q;         // Sticky move done
  logic                  mem_rd_pend_q;  // Memory read in flight
  aether_pkg::word_t     rreg_val;
  aether_pkg::move_cmd_t move_cmd_q;

  logic [16:0]           span, move_len;  // One bit wider, full address space
  aether_pkg::mem_addr_t move_last;

  assign interrupt_o   = mover_busy_i;  // Busy level to host
  assign mem_rd_addr_o = param_2_i;     // Memory registers it, result next cycle
  assign move_cmd_o    = move_cmd_q;

  // ------------------------------
  // Instruction decode
  // ------------------------------
  always_comb begin
    range_reg = (param_1_i == aether_pkg::REG_MSTRT) || (param_1_i == aether_pkg::REG_MENDD);
    do_rst   = 1'b0;
    do_wreg  = 1'b0;
    do_rreg  = 1'b0;
    do_strt  = 1'b0;
    do_cont  = 1'b0;
    do_move  = 1'b0;
    do_mread = 1'b0;
    case (instruction_i)
      aether_pkg::INSTR_RST:      do_rst   = 1'b1;
      aether_pkg::INSTR_WREG:     do_wreg  = !(interrupt_o && range_reg);
      aether_pkg::INSTR_RREG:     do_rreg  = 1'b1;
      aether_pkg::INSTR_LDW_STRT: do_strt  = !interrupt_o;
      aether_pkg::INSTR_LDW_CONT: do_cont  = !interrupt_o;
      aether_pkg::INSTR_LDW_MOVE: do_move  = !interrupt_o;
      aether_pkg::INSTR_MEM_READ: do_mread = 1'b1;
      default: ;  // NOP and unused codes
    endcase
  end

  // Buffer port, RST also empties it
  assign buf_wr_o.clear = do_rst || do_strt;
  assign buf_wr_o.write = do_cont;
  assign buf_wr_o.data  = param_2_i;

  // Register read mux
  always_comb begin
    case (param_1_i)
      aether_pkg::REG_VERSN:  rreg_val = aether_pkg::AETHER_VERSION;
      aether_pkg::REG_MSTRT:  rreg_val = mstrt_q;
      aether_pkg::REG_MENDD:  rreg_val = mendd_q;
      aether_pkg::REG_STATS:  rreg_val = {14'd0, mover_busy_i, done_q || mover_done_i};
      aether_pkg::REG_BUFCNT: rreg_val = aether_pkg::word_t'(buf_count_i);
      default:                rreg_val = '0;
    endcase
  end

  // Move length, range capped by buffer fill
  always_comb begin
    if (mendd_q >= mstrt_q) span = 17'(mendd_q) - 17'(mstrt_q) + 17'd1;
    else span = '0;  // Reversed range
    move_len  = (17'(buf_count_i) < span) ? 17'(buf_count_i) : span;
    move_last = aether_pkg::mem_addr_t'(17'(mstrt_q) + move_len - 17'd1);
  end

  // ------------------------------
  // Registers and data_o
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mstrt_q       <= '0;
      mendd_q       <= '0;
      done_q        <= 1'b0;
      mem_rd_pend_q <= 1'b0;
      move_cmd_q    <= '0;
      data_o        <= '0;
    end else begin
      move_cmd_q.start <= 1'b0;      // One-cycle start pulse
      mem_rd_pend_q    <= do_mread;
      if (do_rst) begin
        mstrt_q       <= '0;
        mendd_q       <= '0;
        done_q        <= 1'b0;
        mem_rd_pend_q <= 1'b0;
        data_o        <= '0;
      end else begin
        if (mover_done_i) done_q <= 1'b1;
        if (do_move) begin
          done_q     <= 1'b0;
          move_cmd_q <= '{start: 1'b1, first: mstrt_q, last: move_last};
        end
        if (do_wreg && param_1_i == aether_pkg::REG_MSTRT) mstrt_q <= param_2_i;
        if (do_wreg && param_1_i == aether_pkg::REG_MENDD) mendd_q <= param_2_i;
        if (mem_rd_pend_q) data_o <= mem_rd_data_i;  // Second stage of MEM_READ
        else if (do_rreg) data_o <= rreg_val;
      end
    end
  end

endmodule

// ==== logic/aether_engine.sv ====
`timescale 1ns/1ps

module aether_engine #(
  parameter int unsigned BufferDepth = 64,   // Input buffer words
  parameter int unsigned MemDepth    = 256   // System memory words
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  aether_pkg::instr_e   instruction_i,
  input  aether_pkg::reg_idx_t param_1_i,
  input  aether_pkg::word_t    param_2_i,
  output aether_pkg::word_t    data_o,
  output logic                 interrupt_o   // Move running, hold off
);

  localparam int unsigned AddrW = $clog2(BufferDepth);
  localparam int unsigned CntW  = $clog2(BufferDepth + 1);

  // ------------------------------
  // Block interconnect
  // ------------------------------
  aether_pkg::buf_wr_t   buf_wr;
  logic [CntW-1:0]       buf_count;
  aether_pkg::move_cmd_t move_cmd;
  logic                  mover_busy;
  logic                  mover_done;   // One-cycle pulse
  logic [AddrW-1:0]      buf_rd_addr;
  aether_pkg::word_t     buf_rd_data;
  aether_pkg::mem_wr_t   mem_wr;
  aether_pkg::mem_addr_t mem_rd_addr;
  aether_pkg::word_t     mem_rd_data;

  // Host side, registers and read-back
  aether_instruct_decoder #(.BufferDepth(BufferDepth)) decode_inst (
    .clk_i,
    .rst_n_i,
    .instruction_i,
    .param_1_i,
    .param_2_i,
    .data_o,
    .buf_count_i   (buf_count),
    .mover_busy_i  (mover_busy),
    .mover_done_i  (mover_done),
    .mem_rd_data_i (mem_rd_data),
    .buf_wr_o      (buf_wr),
    .move_cmd_o    (move_cmd),
    .mem_rd_addr_o (mem_rd_addr),
    .interrupt_o
  );

  aether_input_buffer #(.BufferDepth(BufferDepth)) in_buf_inst (
    .clk_i,
    .rst_n_i,
    .buf_wr_i  (buf_wr),
    .rd_addr_i (buf_rd_addr),
    .rd_data_o (buf_rd_data),
    .count_o   (buf_count)
  );

  // Buffer to memory copy
  aether_buffer_mover #(.BufferDepth(BufferDepth)) mover_inst (
    .clk_i,
    .rst_n_i,
    .move_cmd_i    (move_cmd),
    .buf_rd_addr_o (buf_rd_addr),
    .buf_rd_data_i (buf_rd_data),
    .mem_wr_o      (mem_wr),
    .busy_o        (mover_busy),
    .done_o        (mover_done)
  );

  aether_word_mem #(.MemDepth(MemDepth)) sys_mem_inst (
    .clk_i,
    .mem_wr_i  (mem_wr),
    .rd_addr_i (mem_rd_addr),
    .rd_data_o (mem_rd_data)
  );

endmodule

// ==== test/aether_clock_gen.sv ====
`timescale 1ns/1ps

module aether_clock_gen #(
  parameter real PeriodNs    = 8.0,
  parameter int  ResetCycles = 2
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2.0) clk_o = ~clk_o;
  end

  // Reset held for ResetCycles rising edges, released on a falling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// ==== test/aether_engine_properties.sv ====
`timescale 1ns/1ps

module aether_engine_properties (
  input logic                clk_i,
  input logic                rst_n_i,
  input logic                interrupt_i,
  input logic                busy_i,      // Mover busy
  input logic                done_i,      // Mover done pulse
  input aether_pkg::mem_wr_t mem_wr_i
);

  // Host sees an idle engine right out of reset
  irq_low_after_reset: assert property (@(posedge clk_i) $rose(rst_n_i) |-> !interrupt_i)
    else $error("interrupt_o high in the first cycle after reset");

  // Memory is written only by a running move
  write_only_when_busy: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) mem_wr_i.write |-> busy_i)
    else $error("memory write while the mover is idle");

  done_single_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i) done_i |=> !done_i)
    else $error("mover done pulse longer than one cycle");

  // Done marks the cycle where busy has just dropped
  done_at_busy_fall: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) done_i |-> !busy_i && $past(busy_i))
    else $error("mover done pulse not aligned with the fall of busy");

endmodule

bind aether_engine aether_engine_properties props_inst (
  .clk_i,
  .rst_n_i,
  .interrupt_i (interrupt_o),
  .busy_i      (mover_busy),
  .done_i      (mover_done),
  .mem_wr_i    (mem_wr)
);

// ==== test/aether_engine_tb.sv ====
`timescale 1ns/1ps

module aether_engine_tb;

  localparam int unsigned BufDepth = 16;
  localparam int unsigned MemDepth = 256;
  localparam int unsigned Timeout  = 100;  // Cycles allowed per wait

  logic                 clk_i, rst_n_i, interrupt_o;
  aether_pkg::instr_e   instruction_i;
  aether_pkg::reg_idx_t param_1_i;
  aether_pkg::word_t    param_2_i, data_o;

  // Reference model
  aether_pkg::word_t ref_buf [BufDepth];
  aether_pkg::word_t ref_mem [MemDepth];
  aether_pkg::word_t ref_mstrt, ref_mendd;
  logic              ref_busy, ref_done;
  int unsigned       ref_count, move_len, move_c0;
  int unsigned       cycle_cnt = 0;
  int unsigned       checks = 0, errors = 0, tests = 0, test_err0 = 0;
  int                seed = 32268;
  string             cmp_name;   // Pending read-back
  aether_pkg::word_t cmp_exp;
  event              cmp_ev;

  aether_clock_gen clk_gen (.clk_o(clk_i), .rst_n_o(rst_n_i));

  aether_engine #(.BufferDepth(BufDepth), .MemDepth(MemDepth)) DUT (
    .clk_i, .rst_n_i, .instruction_i, .param_1_i, .param_2_i,
    .data_o, .interrupt_o
  );

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  always @(cmp_ev) check_word(cmp_name, cmp_exp, data_o);  // data_o settled since last rise

  // ------------------------------
  // Compare and reference
  // ------------------------------
  task automatic check_word(string name, aether_pkg::word_t exp, aether_pkg::word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_level(string name, logic exp, logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Mismatch in %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  function automatic aether_pkg::word_t expected_read(aether_pkg::instr_e op,
      aether_pkg::reg_idx_t idx, aether_pkg::word_t addr);
    if (op == aether_pkg::INSTR_MEM_READ) return ref_mem[addr % MemDepth];
    case (idx)
      aether_pkg::REG_VERSN:  return 16'h0A31;
      aether_pkg::REG_MSTRT:  return ref_mstrt;
      aether_pkg::REG_MENDD:  return ref_mendd;
      aether_pkg::REG_STATS:  return {14'd0, ref_busy, ref_done};
      aether_pkg::REG_BUFCNT: return aether_pkg::word_t'(ref_count);
      default:                return '0;  // Unused indices
    endcase
  endfunction

  // Range length capped by the fill level
  function automatic int unsigned move_length();
    int unsigned span;
    span = (ref_mendd >= ref_mstrt) ? int'(ref_mendd) - int'(ref_mstrt) + 1 : 0;
    return (ref_count < span) ? ref_count : span;
  endfunction

  // ------------------------------
  // Host operations
  // ------------------------------
  task automatic abort_run(string what);
    $display("Timeout: %s", what);
    $display("Testbench failed");
    $finish;
  endtask

  // One strobe, returns on the next falling edge
  task automatic send_instr(aether_pkg::instr_e op, aether_pkg::reg_idx_t p1,
      aether_pkg::word_t p2);
    instruction_i = op;
    param_1_i     = p1;
    param_2_i     = p2;
    @(negedge clk_i);
    instruction_i = aether_pkg::INSTR_NOP;
  endtask

  task automatic read_back(string name, aether_pkg::instr_e op, aether_pkg::reg_idx_t idx,
      aether_pkg::word_t addr);
    aether_pkg::word_t exp;
    exp = expected_read(op, idx, addr);
    send_instr(op, idx, addr);
    if (op == aether_pkg::INSTR_MEM_READ) @(negedge clk_i);  // Memory stage
    cmp_name = name;
    cmp_exp  = exp;
    -> cmp_ev;
  endtask

  task automatic read_reg(string name, aether_pkg::reg_idx_t idx);
    read_back(name, aether_pkg::INSTR_RREG, idx, '0);
  endtask

  task automatic read_mem(string name, aether_pkg::word_t addr);
    read_back(name, aether_pkg::INSTR_MEM_READ, '0, addr);
  endtask

  task automatic write_reg(aether_pkg::reg_idx_t idx, aether_pkg::word_t val);
    if (!ref_busy && idx == aether_pkg::REG_MSTRT) ref_mstrt = val;
    if (!ref_busy && idx == aether_pkg::REG_MENDD) ref_mendd = val;
    send_instr(aether_pkg::INSTR_WREG, idx, val);
  endtask

  task automatic start_fill();
    if (!ref_busy) ref_count = 0;
    send_instr(aether_pkg::INSTR_LDW_STRT, '0, '0);
  endtask

  task automatic push_word(aether_pkg::word_t val);
    if (!ref_busy && ref_count < BufDepth) begin
      ref_buf[ref_count] = val;
      ref_count++;
    end
    send_instr(aether_pkg::INSTR_LDW_CONT, '0, val);
  endtask

  task automatic run_move(string name);
    move_len = move_length();
    for (int unsigned k = 0; k < move_len; k++) ref_mem[(ref_mstrt + k) % MemDepth] = ref_buf[k];
    ref_done = 1'b0;
    move_c0  = cycle_cnt;
    send_instr(aether_pkg::INSTR_LDW_MOVE, '0, '0);
    ref_busy = 1'b1;
    check_level({name, " interrupt rise"}, 1'b1, interrupt_o);
  endtask

  // Busy lasts L+2 cycles, one for an empty move
  task automatic wait_idle(string name);
    int unsigned waited;
    waited = 0;
    while (interrupt_o) begin
      @(negedge clk_i);
      waited++;
      if (waited > Timeout) abort_run({name, ": interrupt_o never fell"});
    end
    ref_busy = 1'b0;
    ref_done = 1'b1;
    check_word({name, " busy cycles"}, aether_pkg::word_t'((move_len == 0) ? 1 : move_len + 2),
               aether_pkg::word_t'(cycle_cnt - move_c0 - 1));
  endtask

  task automatic move_range(string name, aether_pkg::word_t first, aether_pkg::word_t last,
      int unsigned nread);
    write_reg(aether_pkg::REG_MSTRT, first);
    write_reg(aether_pkg::REG_MENDD, last);
    run_move(name);
    wait_idle(name);
    read_reg({name, " STATS"}, aether_pkg::REG_STATS);
    for (int unsigned k = 0; k < nread; k++) begin
      read_mem($sformatf("%s mem %0d", name, k), aether_pkg::word_t'(first + k));
    end
  endtask

  task automatic wait_reset();
    int unsigned waited;
    waited = 0;
    while (rst_n_i !== 1'b1) begin
      @(posedge clk_i);
      waited++;
      if (waited > Timeout) abort_run("reset never released");
    end
    @(negedge clk_i);
  endtask

  task automatic finish_test(string name);
    @(negedge clk_i);  // Last compare lands
    tests++;
    $display("Test %s finished with %0d errors", name, errors - test_err0);
    test_err0 = errors;
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    instruction_i = aether_pkg::INSTR_NOP;
    param_1_i     = '0;
    param_2_i     = '0;
    ref_mstrt     = '0;
    ref_mendd     = '0;
    ref_busy      = 1'b0;
    ref_done      = 1'b0;
    ref_count     = 0;
    wait_reset();

    check_level("reset interrupt", 1'b0, interrupt_o);
    for (int i = 0; i < 5; i++) read_reg($sformatf("reset reg %0d", i), aether_pkg::reg_idx_t'(i));
    finish_test("reset_values");

    write_reg(aether_pkg::REG_MSTRT, aether_pkg::word_t'($random(seed)));
    write_reg(aether_pkg::REG_MENDD, aether_pkg::word_t'($random(seed)));
    for (int i = 0; i < 16; i++) begin
      if (i != 1 && i != 2) write_reg(aether_pkg::reg_idx_t'(i), 16'hFFFF);  // Ignored
    end
    for (int i = 0; i < 16; i++) read_reg($sformatf("wreg reg %0d", i), aether_pkg::reg_idx_t'(i));
    finish_test("register_write");

    start_fill();
    read_reg("fill start BUFCNT", aether_pkg::REG_BUFCNT);
    for (int i = 0; i < BufDepth + 3; i++) begin  // Runs past full
      push_word(aether_pkg::word_t'($random(seed)));
      read_reg($sformatf("fill BUFCNT %0d", i), aether_pkg::REG_BUFCNT);
    end
    finish_test("buffer_fill");

    move_range("full move", 16'h0040, 16'h004F, BufDepth);
    start_fill();
    for (int i = 0; i < 5; i++) push_word(aether_pkg::word_t'($random(seed)));
    move_range("capped move", 16'h003C, 16'h004B, BufDepth);  // Tail keeps old words
    move_range("short range", 16'h0042, 16'h0043, 6);
    move_range("reversed range", 16'h0050, 16'h004F, 0);
    finish_test("buffer_move");

    start_fill();
    for (int i = 0; i < 12; i++) push_word(aether_pkg::word_t'($random(seed)));
    write_reg(aether_pkg::REG_MSTRT, 16'h0080);
    write_reg(aether_pkg::REG_MENDD, 16'h008B);
    run_move("busy move");
    push_word(16'hDEAD);                        // All gated while busy
    write_reg(aether_pkg::REG_MSTRT, 16'h1234);
    start_fill();
    read_reg("busy STATS", aether_pkg::REG_STATS);
    wait_idle("busy move");
    read_reg("busy BUFCNT", aether_pkg::REG_BUFCNT);
    read_reg("busy MSTRT", aether_pkg::REG_MSTRT);
    for (int unsigned k = 0; k < 12; k++) begin
      read_mem($sformatf("busy mem %0d", k), aether_pkg::word_t'(16'h0080 + k));
    end
    finish_test("busy_gate");

    write_reg(aether_pkg::REG_MSTRT, 16'h0011);
    write_reg(aether_pkg::REG_MENDD, 16'h0022);
    send_instr(aether_pkg::INSTR_RST, '0, '0);
    ref_mstrt = '0;
    ref_mendd = '0;
    ref_done  = 1'b0;
    ref_count = 0;
    check_word("RST data_o", '0, data_o);
    for (int i = 1; i < 5; i++) read_reg($sformatf("RST reg %0d", i), aether_pkg::reg_idx_t'(i));
    read_mem("RST mem 0x80", 16'h0080);  // Memory survives RST
    read_mem("RST mem 0x4A", 16'h004A);
    finish_test("soft_reset");

    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== aether_engine.f ====
logic/aether_pkg.sv
logic/aether_word_mem.sv
logic/aether_input_buffer.sv
logic/aether_buffer_mover.sv
logic/aether_instruct_decoder.sv
logic/aether_engine.sv
test/aether_clock_gen.sv
test/aether_engine_properties.sv
test/aether_engine_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = aether_engine_tb
FILELIST = aether_engine.f
BUILD    = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# The run passes only if the pass line shows up in the output
test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee /dev/stderr | grep -x "Testbench passed" > /dev/null

clean:
	rm -rf $(BUILD)
